// ==== src/rv_dec_pkg.sv ====
// shared types for the RV32 decoder
// RV32I plus M only, no compressed, no bitmanip, no RV32E
// RV32M is fixed here and is not a module parameter
package rv_dec_pkg;

  ////////////////////////////////////////////////
  // widths and constants
  ////////////////////////////////////////////////
  typedef logic [31:0] instr_t;      // raw instruction word
  typedef logic [31:0] word_t;       // data or immediate
  typedef logic [4:0]  reg_addr_t;   // x0..x31
  typedef logic [1:0]  data_type_t;  // lsu access size
  typedef logic [1:0]  md_signed_t;  // {op_b signed, op_a signed}

  localparam bit RV32M = 1'b1;  // mul/div decode enable

  // field lsb positions inside instr_t
  localparam int unsigned OPCODE_LSB = 0;
  localparam int unsigned RD_LSB     = 7;
  localparam int unsigned FUNCT3_LSB = 12;
  localparam int unsigned RS1_LSB    = 15;
  localparam int unsigned RS2_LSB    = 20;
  localparam int unsigned FUNCT7_LSB = 25;

  localparam data_type_t DT_WORD = 2'd0;
  localparam data_type_t DT_HALF = 2'd1;
  localparam data_type_t DT_BYTE = 2'd2;

  localparam word_t PC_INCR = 32'd4;  // no compressed, always 4

  ////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////
  typedef enum logic [6:0] {
    OPCODE_LOAD     = 7'h03,
    OPCODE_MISC_MEM = 7'h0f,
    OPCODE_OP_IMM   = 7'h13,
    OPCODE_AUIPC    = 7'h17,
    OPCODE_STORE    = 7'h23,
    OPCODE_OP       = 7'h33,
    OPCODE_LUI      = 7'h37,
    OPCODE_BRANCH   = 7'h63,
    OPCODE_JALR     = 7'h67,
    OPCODE_JAL      = 7'h6f,
    OPCODE_SYSTEM   = 7'h73
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB,
    ALU_XOR, ALU_OR, ALU_AND,
    ALU_SRA, ALU_SRL, ALU_SLL,
    ALU_LT, ALU_LTU, ALU_GE, ALU_GEU, ALU_EQ, ALU_NE,  // branch compares
    ALU_SLT, ALU_SLTU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_IMM} op_a_sel_e;
  typedef enum logic       {OP_B_REG_B, OP_B_IMM} op_b_sel_e;
  typedef enum logic       {IMM_A_ZERO, IMM_A_Z} imm_a_sel_e;  // Z = csr zimm
  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J, IMM_B_INCR_PC
  } imm_b_sel_e;
  typedef enum logic [1:0] {MD_OP_MULL, MD_OP_MULH, MD_OP_DIV, MD_OP_REM} md_op_e;
  typedef enum logic [1:0] {CSR_OP_READ, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR} csr_op_e;
  typedef enum logic       {RF_WD_EX, RF_WD_CSR} rf_wd_sel_e;

  ////////////////////////////////////////////////
  // decoded records
  ////////////////////////////////////////////////
  typedef struct packed {
    logic       illegal;
    logic       rf_we;
    logic       rf_ren_a;
    logic       rf_ren_b;
    rf_wd_sel_e rf_wdata_sel;
    logic       data_req;
    logic       data_we;
    data_type_t data_type;
    logic       data_sign_ext;
    logic       mult_en;
    logic       div_en;
    md_op_e     md_op;
    md_signed_t md_signed;
    logic       csr_access;
    csr_op_e    csr_op;
    logic       jump;          // target calc in alu
    logic       branch;
    logic       icache_inval;  // fence.i
    logic       ecall;
    logic       ebrk;
    logic       mret;
    logic       dret;
    logic       wfi;
  } ctrl_dec_t;

  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
  } reg_sel_t;

  typedef struct packed {
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_a_sel_e imm_a_sel;
    imm_b_sel_e imm_b_sel;
    logic       multdiv_sel;
    word_t      imm_b;        // already picked by imm_b_sel
    logic [4:0] zimm;         // csr uimm, zero extended downstream
  } alu_dec_t;

  typedef struct packed {
    ctrl_dec_t ctrl;
    reg_sel_t  regs;
    alu_dec_t  alu;
  } decoded_t;

endpackage

// ==== src/rv_ctrl_decoder.sv ====
// control half of the decoder, purely combinational
// jumps/branches decode in target-calc form only, link write is left to later stages
// illegal encodings squash all side effects, system flags are left as decoded
`timescale 1ns/1ps

module rv_ctrl_decoder (
  input  rv_dec_pkg::instr_t    instr_i,
  output rv_dec_pkg::ctrl_dec_t ctrl_o,
  output rv_dec_pkg::reg_sel_t  regs_o
);

  import rv_dec_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rs1, rd;
  ctrl_dec_t  ctrl;  // before csr fix-up

  assign opcode = opcode_e'(instr_i[OPCODE_LSB +: 7]);
  assign funct3 = instr_i[FUNCT3_LSB +: 3];
  assign funct7 = instr_i[FUNCT7_LSB +: 7];
  assign rs1    = instr_i[RS1_LSB +: 5];
  assign rd     = instr_i[RD_LSB +: 5];

  assign regs_o = '{rs1: rs1, rs2: instr_i[RS2_LSB +: 5], rd: rd};

  //////////////////////////////////////////////////
  // main decode
  //////////////////////////////////////////////////
  always_comb begin
    ctrl = '0;  // all enums encode their default as 0

    unique case (opcode)
      OPCODE_JAL: begin
        ctrl.jump  = 1'b1;
        ctrl.rf_we = 1'b1;  // link
      end
      OPCODE_JALR: begin
        ctrl.jump     = 1'b1;
        ctrl.rf_we    = 1'b1;
        ctrl.rf_ren_a = 1'b1;
        ctrl.illegal  = (funct3 != 3'b000);
      end
      OPCODE_BRANCH: begin
        ctrl.branch   = 1'b1;
        ctrl.rf_ren_a = 1'b1;
        ctrl.rf_ren_b = 1'b1;
        ctrl.illegal  = (funct3[2:1] == 2'b01);  // 010/011 unused
      end

      OPCODE_STORE: begin
        ctrl.rf_ren_a = 1'b1;
        ctrl.rf_ren_b = 1'b1;
        ctrl.data_req = 1'b1;
        ctrl.data_we  = 1'b1;
        ctrl.illegal  = funct3[2];  // no unsigned stores
        unique case (funct3[1:0])
          2'b00:   ctrl.data_type = DT_BYTE;  // sb
          2'b01:   ctrl.data_type = DT_HALF;  // sh
          2'b10:   ctrl.data_type = DT_WORD;  // sw
          default: ctrl.illegal   = 1'b1;
        endcase
      end
      OPCODE_LOAD: begin
        ctrl.rf_ren_a      = 1'b1;
        ctrl.rf_we         = 1'b1;
        ctrl.data_req      = 1'b1;
        ctrl.data_sign_ext = ~funct3[2];
        unique case (funct3[1:0])
          2'b00:   ctrl.data_type = DT_BYTE;
          2'b01:   ctrl.data_type = DT_HALF;
          2'b10:   ctrl.illegal   = funct3[2];  // lwu
          default: ctrl.illegal   = 1'b1;
        endcase
      end

      OPCODE_LUI, OPCODE_AUIPC: ctrl.rf_we = 1'b1;
      OPCODE_OP_IMM: begin
        ctrl.rf_ren_a = 1'b1;
        ctrl.rf_we    = 1'b1;
        if (funct3 == 3'b001) begin
          ctrl.illegal = (funct7 != 7'b000_0000);  // slli
        end else if (funct3 == 3'b101) begin
          ctrl.illegal = (funct7 != 7'b000_0000) && (funct7 != 7'b010_0000);
        end
      end
      OPCODE_OP: begin
        ctrl.rf_ren_a = 1'b1;
        ctrl.rf_ren_b = 1'b1;
        ctrl.rf_we    = 1'b1;
        if (funct7 == 7'b000_0001) begin  // M extension
          ctrl.mult_en = RV32M & ~funct3[2];
          ctrl.div_en  = RV32M & funct3[2];
          ctrl.illegal = !RV32M;
          unique case (funct3)
            3'b000: ctrl.md_op = MD_OP_MULL;
            3'b001: begin ctrl.md_op = MD_OP_MULH; ctrl.md_signed = 2'b11; end
            3'b010: begin ctrl.md_op = MD_OP_MULH; ctrl.md_signed = 2'b01; end  // mulhsu
            3'b011: ctrl.md_op = MD_OP_MULH;
            3'b100: begin ctrl.md_op = MD_OP_DIV;  ctrl.md_signed = 2'b11; end
            3'b101: ctrl.md_op = MD_OP_DIV;
            3'b110: begin ctrl.md_op = MD_OP_REM;  ctrl.md_signed = 2'b11; end
            default: ctrl.md_op = MD_OP_REM;  // remu
          endcase
        end else begin
          unique case ({funct7, funct3})
            {7'b000_0000, 3'b000}, {7'b010_0000, 3'b000},  // add sub
            {7'b000_0000, 3'b001}, {7'b000_0000, 3'b010},
            {7'b000_0000, 3'b011}, {7'b000_0000, 3'b100},
            {7'b000_0000, 3'b101}, {7'b010_0000, 3'b101},  // srl sra
            {7'b000_0000, 3'b110}, {7'b000_0000, 3'b111}: ctrl.illegal = 1'b0;
            default: ctrl.illegal = 1'b1;
          endcase
        end
      end

      OPCODE_MISC_MEM: begin
        unique case (funct3)
          3'b000: ;  // fence, nop here
          3'b001: begin  // fence.i, jump to pc+4 flushes fetch
            ctrl.jump         = 1'b1;
            ctrl.icache_inval = 1'b1;
          end
          default: ctrl.illegal = 1'b1;
        endcase
      end
      OPCODE_SYSTEM: begin
        if (funct3 == 3'b000) begin
          unique case (instr_i[31:20])
            12'h000: ctrl.ecall = 1'b1;
            12'h001: ctrl.ebrk  = 1'b1;
            12'h302: ctrl.mret  = 1'b1;
            12'h7b2: ctrl.dret  = 1'b1;
            12'h105: ctrl.wfi   = 1'b1;
            default: ctrl.illegal = 1'b1;
          endcase
          if (rs1 != '0 || rd != '0) ctrl.illegal = 1'b1;
        end else begin
          ctrl.csr_access   = 1'b1;
          ctrl.rf_wdata_sel = RF_WD_CSR;
          ctrl.rf_we        = 1'b1;
          ctrl.rf_ren_a     = ~funct3[2];  // imm forms don't read rs1
          unique case (funct3[1:0])
            2'b01:   ctrl.csr_op  = CSR_OP_WRITE;
            2'b10:   ctrl.csr_op  = CSR_OP_SET;
            2'b11:   ctrl.csr_op  = CSR_OP_CLEAR;
            default: ctrl.illegal = 1'b1;
          endcase
        end
      end
      default: ctrl.illegal = 1'b1;
    endcase

    // keep illegal instrs away from rf, lsu, md unit, csrs and pc
    if (ctrl.illegal) begin
      ctrl.rf_we        = 1'b0;
      ctrl.data_req     = 1'b0;
      ctrl.data_we      = 1'b0;
      ctrl.mult_en      = 1'b0;
      ctrl.div_en       = 1'b0;
      ctrl.jump         = 1'b0;
      ctrl.branch       = 1'b0;
      ctrl.csr_access   = 1'b0;
      ctrl.icache_inval = 1'b0;
    end
  end

  // set/clear from x0 or uimm 0 must not write the csr
  always_comb begin
    ctrl_o = ctrl;
    if ((ctrl.csr_op == CSR_OP_SET || ctrl.csr_op == CSR_OP_CLEAR) && rs1 == '0) begin
      ctrl_o.csr_op = CSR_OP_READ;
    end
  end

endmodule

// ==== src/rv_alu_decoder.sv ====
// alu half of the decoder, purely combinational
// jumps and branches get their target-calc selects, branches carry the compare op
// imm_b is already muxed, zimm is the raw rs1 field
`timescale 1ns/1ps

module rv_alu_decoder (
  input  rv_dec_pkg::instr_t   instr_i,
  output rv_dec_pkg::alu_dec_t alu_o
);

  import rv_dec_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  alu_op_e    alu_op;
  op_a_sel_e  op_a_sel;
  op_b_sel_e  op_b_sel;
  imm_a_sel_e imm_a_sel;
  imm_b_sel_e imm_b_sel;
  logic       multdiv_sel;
  word_t      imm_b;

  assign opcode = opcode_e'(instr_i[OPCODE_LSB +: 7]);
  assign funct3 = instr_i[FUNCT3_LSB +: 3];
  assign funct7 = instr_i[FUNCT7_LSB +: 7];

  //////////////////////////////////////////////////
  // operator and selects
  //////////////////////////////////////////////////
  always_comb begin
    alu_op      = ALU_SLTU;
    op_a_sel    = OP_A_IMM;
    op_b_sel    = OP_B_IMM;
    imm_a_sel   = IMM_A_ZERO;
    imm_b_sel   = IMM_B_I;
    multdiv_sel = 1'b0;

    unique case (opcode)
      OPCODE_JAL: begin op_a_sel = OP_A_CURRPC; imm_b_sel = IMM_B_J; alu_op = ALU_ADD; end
      OPCODE_JALR: begin op_a_sel = OP_A_REG_A; alu_op = ALU_ADD; end  // rs1 + imm_i
      OPCODE_BRANCH: begin
        op_a_sel  = OP_A_CURRPC;  // pc + imm_b is the target
        imm_b_sel = IMM_B_B;
        unique case (funct3)
          3'b000:  alu_op = ALU_EQ;
          3'b001:  alu_op = ALU_NE;
          3'b100:  alu_op = ALU_LT;
          3'b101:  alu_op = ALU_GE;
          3'b110:  alu_op = ALU_LTU;
          3'b111:  alu_op = ALU_GEU;
          default: ;  // illegal, ctrl side flags it
        endcase
      end
      OPCODE_STORE: begin op_a_sel = OP_A_REG_A; imm_b_sel = IMM_B_S; alu_op = ALU_ADD; end
      OPCODE_LOAD:  begin op_a_sel = OP_A_REG_A; alu_op = ALU_ADD; end
      OPCODE_LUI:   begin imm_b_sel = IMM_B_U; alu_op = ALU_ADD; end  // 0 + imm_u
      OPCODE_AUIPC: begin op_a_sel = OP_A_CURRPC; imm_b_sel = IMM_B_U; alu_op = ALU_ADD; end
      OPCODE_OP_IMM: begin
        op_a_sel = OP_A_REG_A;
        unique case (funct3)
          3'b000: alu_op = ALU_ADD;
          3'b001: alu_op = ALU_SLL;
          3'b010: alu_op = ALU_SLT;
          3'b011: alu_op = ALU_SLTU;
          3'b100: alu_op = ALU_XOR;
          3'b101: alu_op = (funct7 == 7'b010_0000) ? ALU_SRA : ALU_SRL;
          3'b110: alu_op = ALU_OR;
          default: alu_op = ALU_AND;
        endcase
      end
      OPCODE_OP: begin
        op_a_sel = OP_A_REG_A;
        op_b_sel = OP_B_REG_B;
        if (funct7 == 7'b000_0001) begin
          multdiv_sel = 1'b1;  // all M ops use the adder path
          alu_op      = ALU_ADD;
        end else begin
          unique case (funct3)
            3'b000: alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
            3'b001: alu_op = ALU_SLL;
            3'b010: alu_op = ALU_SLT;
            3'b011: alu_op = ALU_SLTU;
            3'b100: alu_op = ALU_XOR;
            3'b101: alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110: alu_op = ALU_OR;
            default: alu_op = ALU_AND;
          endcase
        end
      end
      OPCODE_MISC_MEM: begin
        alu_op = ALU_ADD;
        if (funct3 == 3'b001) begin  // fence.i, jump to pc+4
          op_a_sel  = OP_A_CURRPC;
          imm_b_sel = IMM_B_INCR_PC;
        end else begin
          op_a_sel  = OP_A_REG_A;
        end
      end
      OPCODE_SYSTEM: begin
        if (funct3 != 3'b000) begin
          imm_a_sel = IMM_A_Z;  // csr addr sits in imm_i
          op_a_sel  = funct3[2] ? OP_A_IMM : OP_A_REG_A;
        end else begin
          op_a_sel  = OP_A_REG_A;
        end
      end
      default: ;
    endcase
  end

  // sign-extended operand b immediate
  always_comb begin
    unique case (imm_b_sel)
      IMM_B_S: imm_b = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
      IMM_B_B: imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                        instr_i[11:8], 1'b0};
      IMM_B_U: imm_b = {instr_i[31:12], 12'b0};
      IMM_B_J: imm_b = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
      IMM_B_INCR_PC: imm_b = PC_INCR;
      default: imm_b = {{20{instr_i[31]}}, instr_i[31:20]};  // I type
    endcase
  end

  assign alu_o = '{
    alu_op:      alu_op,
    op_a_sel:    op_a_sel,
    op_b_sel:    op_b_sel,
    imm_a_sel:   imm_a_sel,
    imm_b_sel:   imm_b_sel,
    multdiv_sel: multdiv_sel,
    imm_b:       imm_b,
    zimm:        instr_i[RS1_LSB +: 5]
  };

endmodule

// ==== src/rv_dec_output_stage.sv ====
// one-entry valid/ready slice for the decoded record
// full throughput when downstream is ready, one item in flight
// ready depends combinationally on out_ready_i
`timescale 1ns/1ps

module rv_dec_output_stage (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  rv_dec_pkg::ctrl_dec_t ctrl_i,
  input  rv_dec_pkg::reg_sel_t  regs_i,
  input  rv_dec_pkg::alu_dec_t  alu_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output rv_dec_pkg::decoded_t  dec_o
);

  import rv_dec_pkg::*;

  decoded_t dec_d, dec_q;
  logic     valid_q;

  assign dec_d      = '{ctrl: ctrl_i, regs: regs_i, alu: alu_i};
  assign in_ready_o = ~valid_q | out_ready_i;  // empty, or drained this cycle

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) dec_q <= dec_d;  // load on accept only
  end

  assign out_valid_o = valid_q;
  assign dec_o       = dec_q;

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(dec_o));

  // squash in the ctrl decoder must reach the held record
  a_illegal_squashed: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && dec_o.ctrl.illegal |-> !(dec_o.ctrl.rf_we || dec_o.ctrl.data_req ||
      dec_o.ctrl.data_we || dec_o.ctrl.mult_en || dec_o.ctrl.div_en || dec_o.ctrl.jump ||
      dec_o.ctrl.branch || dec_o.ctrl.csr_access || dec_o.ctrl.icache_inval));

  a_valid_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown(out_valid_o));

endmodule

// ==== src/rv_decode_top.sv ====
// RV32IM decoder between fetch and execute
// instr_i must hold while instr_valid_i is high and instr_ready_o low
// one cycle from accept to dec_valid_o
`timescale 1ns/1ps

module rv_decode_top (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 instr_valid_i,
  output logic                 instr_ready_o,
  input  rv_dec_pkg::instr_t   instr_i,
  output logic                 dec_valid_o,
  input  logic                 dec_ready_i,
  output rv_dec_pkg::decoded_t dec_o
);

  import rv_dec_pkg::*;

  ctrl_dec_t ctrl;
  reg_sel_t  regs;
  alu_dec_t  alu;

  // both decoders see the same word
  rv_ctrl_decoder u_ctrl_dec (
    .instr_i (instr_i),
    .ctrl_o  (ctrl),
    .regs_o  (regs)
  );

  rv_alu_decoder u_alu_dec (
    .instr_i (instr_i),
    .alu_o   (alu)
  );

  rv_dec_output_stage u_out_stage (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (instr_valid_i),
    .in_ready_o  (instr_ready_o),
    .ctrl_i      (ctrl),
    .regs_i      (regs),
    .alu_i       (alu),
    .out_valid_o (dec_valid_o),
    .out_ready_i (dec_ready_i),
    .dec_o       (dec_o)
  );

endmodule

// ==== testbench/rv_dec_model.svh ====
// reference decoder for the testbench, RV32IM only
// include inside a module that already imports rv_dec_pkg
// unknown opcodes keep the all-default alu fields
`ifndef RV_DEC_MODEL_SVH
`define RV_DEC_MODEL_SVH

// shared funct3 map of OP and OP-IMM
function automatic alu_op_e arith_op(input logic [2:0] f3, input logic sub, input logic sra);
  case (f3)
    3'd0:    arith_op = sub ? ALU_SUB : ALU_ADD;
    3'd1:    arith_op = ALU_SLL;
    3'd2:    arith_op = ALU_SLT;
    3'd3:    arith_op = ALU_SLTU;
    3'd4:    arith_op = ALU_XOR;
    3'd5:    arith_op = sra ? ALU_SRA : ALU_SRL;
    3'd6:    arith_op = ALU_OR;
    default: arith_op = ALU_AND;
  endcase
endfunction

function automatic alu_op_e branch_cmp(input logic [2:0] f3);
  case (f3)
    3'd0:    branch_cmp = ALU_EQ;
    3'd1:    branch_cmp = ALU_NE;
    3'd4:    branch_cmp = ALU_LT;
    3'd5:    branch_cmp = ALU_GE;
    3'd6:    branch_cmp = ALU_LTU;
    3'd7:    branch_cmp = ALU_GEU;
    default: branch_cmp = ALU_SLTU;  // unused funct3, flagged illegal
  endcase
endfunction

// immediate formats straight from the ISA tables
function automatic word_t operand_b_imm(input instr_t w, input imm_b_sel_e sel);
  case (sel)
    IMM_B_S:       operand_b_imm = {{20{w[31]}}, w[31:25], w[11:7]};
    IMM_B_B:       operand_b_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    IMM_B_U:       operand_b_imm = {w[31:12], 12'h000};
    IMM_B_J:       operand_b_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    IMM_B_INCR_PC: operand_b_imm = 32'd4;
    default:       operand_b_imm = {{20{w[31]}}, w[31:20]};
  endcase
endfunction

function automatic ctrl_dec_t control_fields(input instr_t w);
  ctrl_dec_t  c;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       bad;
  f3  = w[14:12];
  f7  = w[31:25];
  c   = '0;
  bad = 1'b0;
  case (w[6:0])
    OPCODE_JAL: begin
      c.jump  = 1'b1;
      c.rf_we = 1'b1;  // link written later
    end
    OPCODE_JALR: begin
      c.jump     = 1'b1;
      c.rf_we    = 1'b1;
      c.rf_ren_a = 1'b1;
      bad        = (f3 != 3'd0);
    end
    OPCODE_BRANCH: begin
      c.branch   = 1'b1;
      c.rf_ren_a = 1'b1;
      c.rf_ren_b = 1'b1;
      bad        = (f3 == 3'd2) || (f3 == 3'd3);
    end
    OPCODE_LOAD: begin
      c.rf_we         = 1'b1;
      c.rf_ren_a      = 1'b1;
      c.data_req      = 1'b1;
      c.data_sign_ext = !f3[2];  // lbu/lhu zero extend
      c.data_type     = (f3[1:0] == 2'd0) ? 2'd2 : (f3[1:0] == 2'd1) ? 2'd1 : 2'd0;
      bad             = (f3[1:0] == 2'd3) || (f3 == 3'b110);  // lwu
    end
    OPCODE_STORE: begin
      c.rf_ren_a  = 1'b1;
      c.rf_ren_b  = 1'b1;
      c.data_req  = 1'b1;
      c.data_we   = 1'b1;
      c.data_type = (f3[1:0] == 2'd0) ? 2'd2 : (f3[1:0] == 2'd1) ? 2'd1 : 2'd0;
      bad         = f3[2] || (f3[1:0] == 2'd3);
    end
    OPCODE_LUI, OPCODE_AUIPC: c.rf_we = 1'b1;
    OPCODE_OP_IMM: begin
      c.rf_we    = 1'b1;
      c.rf_ren_a = 1'b1;
      bad = ((f3 == 3'd1) && (f7 != 7'h00)) ||
            ((f3 == 3'd5) && (f7 != 7'h00) && (f7 != 7'h20));
    end
    OPCODE_OP: begin
      c.rf_we    = 1'b1;
      c.rf_ren_a = 1'b1;
      c.rf_ren_b = 1'b1;
      if (f7 == 7'h01) begin
        c.mult_en = RV32M && !f3[2];
        c.div_en  = RV32M && f3[2];
        bad       = !RV32M;
        if (f3[2]) c.md_op = f3[1] ? MD_OP_REM : MD_OP_DIV;
        else       c.md_op = (f3[1:0] == 2'd0) ? MD_OP_MULL : MD_OP_MULH;
        case (f3)
          3'd1, 3'd4, 3'd6: c.md_signed = 2'b11;  // mulh div rem
          3'd2:             c.md_signed = 2'b01;  // mulhsu
          default:          c.md_signed = 2'b00;
        endcase
      end else begin
        bad = !((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5))));
      end
    end
    OPCODE_MISC_MEM: begin
      c.jump         = (f3 == 3'd1);  // fence.i refetches
      c.icache_inval = (f3 == 3'd1);
      bad            = (f3 > 3'd1);
    end
    OPCODE_SYSTEM: begin
      if (f3 == 3'd0) begin
        c.ecall = (w[31:20] == 12'h000);
        c.ebrk  = (w[31:20] == 12'h001);
        c.mret  = (w[31:20] == 12'h302);
        c.dret  = (w[31:20] == 12'h7b2);
        c.wfi   = (w[31:20] == 12'h105);
        bad = !(c.ecall || c.ebrk || c.mret || c.dret || c.wfi) ||
              (w[19:15] != 5'd0) || (w[11:7] != 5'd0);
      end else begin
        c.csr_access   = 1'b1;
        c.rf_wdata_sel = RF_WD_CSR;
        c.rf_we        = 1'b1;
        c.rf_ren_a     = !f3[2];
        c.csr_op       = csr_op_e'(f3[1:0]);  // same order as the ISA
        bad            = (f3[1:0] == 2'd0);
        if (f3[1] && (w[19:15] == 5'd0)) c.csr_op = CSR_OP_READ;  // no write from zero
      end
    end
    default: bad = 1'b1;
  endcase
  c.illegal = bad;
  if (bad) begin
    c.rf_we        = 1'b0;
    c.data_req     = 1'b0;
    c.data_we      = 1'b0;
    c.mult_en      = 1'b0;
    c.div_en       = 1'b0;
    c.jump         = 1'b0;
    c.branch       = 1'b0;
    c.csr_access   = 1'b0;
    c.icache_inval = 1'b0;
  end
  return c;
endfunction

function automatic alu_dec_t alu_fields(input instr_t w);
  alu_dec_t   a;
  logic [2:0] f3;
  logic [6:0] f7;
  f3 = w[14:12];
  f7 = w[31:25];
  a  = '{alu_op: ALU_SLTU, op_a_sel: OP_A_IMM, op_b_sel: OP_B_IMM, imm_a_sel: IMM_A_ZERO,
         imm_b_sel: IMM_B_I, multdiv_sel: 1'b0, imm_b: '0, zimm: w[19:15]};
  case (w[6:0])
    OPCODE_JAL: begin
      a.op_a_sel  = OP_A_CURRPC;
      a.imm_b_sel = IMM_B_J;
      a.alu_op    = ALU_ADD;
    end
    OPCODE_JALR, OPCODE_LOAD: begin
      a.op_a_sel = OP_A_REG_A;
      a.alu_op   = ALU_ADD;
    end
    OPCODE_STORE: begin
      a.op_a_sel  = OP_A_REG_A;
      a.imm_b_sel = IMM_B_S;
      a.alu_op    = ALU_ADD;
    end
    OPCODE_BRANCH: begin
      a.op_a_sel  = OP_A_CURRPC;
      a.imm_b_sel = IMM_B_B;
      a.alu_op    = branch_cmp(f3);
    end
    OPCODE_LUI: begin
      a.imm_b_sel = IMM_B_U;
      a.alu_op    = ALU_ADD;
    end
    OPCODE_AUIPC: begin
      a.op_a_sel  = OP_A_CURRPC;
      a.imm_b_sel = IMM_B_U;
      a.alu_op    = ALU_ADD;
    end
    OPCODE_OP_IMM: begin
      a.op_a_sel = OP_A_REG_A;
      a.alu_op   = arith_op(f3, 1'b0, f7 == 7'h20);  // no subi
    end
    OPCODE_OP: begin
      a.op_a_sel    = OP_A_REG_A;
      a.op_b_sel    = OP_B_REG_B;
      a.multdiv_sel = (f7 == 7'h01);
      a.alu_op      = a.multdiv_sel ? ALU_ADD : arith_op(f3, f7[5], f7[5]);
    end
    OPCODE_MISC_MEM: begin
      a.alu_op    = ALU_ADD;
      a.op_a_sel  = (f3 == 3'd1) ? OP_A_CURRPC : OP_A_REG_A;
      a.imm_b_sel = (f3 == 3'd1) ? IMM_B_INCR_PC : IMM_B_I;
    end
    OPCODE_SYSTEM: begin
      a.op_a_sel  = (f3 != 3'd0 && f3[2]) ? OP_A_IMM : OP_A_REG_A;
      a.imm_a_sel = (f3 != 3'd0) ? IMM_A_Z : IMM_A_ZERO;
    end
    default: ;
  endcase
  a.imm_b = operand_b_imm(w, a.imm_b_sel);
  return a;
endfunction

function automatic decoded_t decode_word(input instr_t w);
  decoded_t d;
  d.ctrl = control_fields(w);
  d.regs = '{rs1: w[19:15], rs2: w[24:20], rd: w[11:7]};
  d.alu  = alu_fields(w);
  return d;
endfunction

`endif

// ==== testbench/tb_rv_decode.sv ====
// testbench for rv_decode_top, random RV32IM words against the model in rv_dec_model.svh
// all randomness comes from the seeded main thread, inputs change on rising edges only
// needs testbench/ on the include path
`timescale 1ns/1ps

module tb_rv_decode;

  import rv_dec_pkg::*;

  `include "rv_dec_model.svh"

  localparam int N_PER_TEST = 300;
  localparam int N_KINDS    = 6;
  localparam int TIMEOUT_NS = N_PER_TEST * N_KINDS * 8 * 4 + 2000;  // worst stall ratio 8
  localparam int T_ALU  = 0;
  localparam int T_LS   = 1;
  localparam int T_MD   = 2;
  localparam int T_RAND = 3;
  localparam int T_CSR  = 4;
  localparam int T_JMP  = 5;
  localparam int T_HS   = 6;  // handshake checks, not a driven kind

  string names [7] = '{"alu_ops", "load_store", "muldiv", "random_word", "csr_system",
                       "jump_fence", "handshake"};

  logic     clk;
  logic     arst_n;
  logic     instr_valid;
  logic     instr_ready;
  instr_t   instr;
  logic     dec_valid;
  logic     dec_ready;
  decoded_t dec;
  logic [2:0] instr_test;  // kind of the word on instr, travels with it

  decoded_t exp_q [$];
  int       id_q [$];
  int       checks [7];
  int       errors [7];
  logic     stalled = 1'b0;
  logic     accepted = 1'b0;  // handshake seen at the previous edge
  decoded_t held;

  rv_decode_top UUT (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .instr_valid_i (instr_valid),
    .instr_ready_o (instr_ready),
    .instr_i       (instr),
    .dec_valid_o   (dec_valid),
    .dec_ready_i   (dec_ready),
    .dec_o         (dec)
  );

  always #2 clk = ~clk;

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  function automatic instr_t make_instr(input int kind);
    instr_t w;
    w = $urandom;  // random fields everywhere, templates patch them
    case (kind)
      T_ALU: begin
        case ($urandom_range(3))
          0: begin
            w[6:0]   = OPCODE_OP;
            w[31:25] = ((w[14:12] == 3'd0 || w[14:12] == 3'd5) && $urandom_range(1)) ?
                       7'h20 : 7'h00;
          end
          1: begin
            w[6:0] = OPCODE_OP_IMM;
            if (w[14:12] == 3'd1) w[31:25] = 7'h00;  // slli
            if (w[14:12] == 3'd5) w[31:25] = $urandom_range(1) ? 7'h20 : 7'h00;
          end
          2:       w[6:0] = OPCODE_LUI;
          default: w[6:0] = OPCODE_AUIPC;
        endcase
      end
      T_LS: w[6:0] = $urandom_range(1) ? OPCODE_STORE : OPCODE_LOAD;  // all funct3 incl lwu
      T_MD: begin
        w[31:25] = 7'h01;
        w[6:0]   = OPCODE_OP;
      end
      T_CSR: begin
        case ($urandom_range(2))
          0: begin
            w[6:0]   = OPCODE_SYSTEM;
            w[14:12] = 3'($urandom_range(7, 1));
            if ($urandom_range(1)) w[19:15] = 5'd0;  // set/clear become reads
          end
          1: begin
            w[6:0]   = OPCODE_SYSTEM;
            w[14:12] = 3'd0;
            case ($urandom_range(4))
              0:       w[31:20] = 12'h000;
              1:       w[31:20] = 12'h001;
              2:       w[31:20] = 12'h302;
              3:       w[31:20] = 12'h7b2;
              default: w[31:20] = 12'h105;
            endcase
            if ($urandom_range(7) != 0) begin
              w[19:15] = 5'd0;
              w[11:7]  = 5'd0;
            end
          end
          default: begin
            w[6:0] = OPCODE_MISC_MEM;
            if ($urandom_range(3) != 0) w[14:13] = 2'd0;  // mostly fence / fence.i
          end
        endcase
      end
      T_JMP: begin
        case ($urandom_range(2))
          0: w[6:0] = OPCODE_JAL;
          1: begin
            w[6:0] = OPCODE_JALR;
            if ($urandom_range(3) != 0) w[14:12] = 3'd0;
          end
          default: w[6:0] = OPCODE_BRANCH;
        endcase
      end
      T_RAND: ;  // raw word, mostly unknown opcodes
    endcase
    return w;
  endfunction

  // one clock, consumer readiness redrawn on the edge
  task automatic step_clock();
    @(posedge clk);
    dec_ready <= ($urandom_range(3) != 0);
  endtask

  task automatic drive_test(input int kind, input int n);
    int sent;
    sent = 0;
    while (sent < n) begin
      step_clock();
      if (instr_valid && instr_ready) sent++;  // offer taken at this edge
      if (!instr_valid || instr_ready) begin
        if (sent < n && $urandom_range(3) != 0) begin
          instr_valid <= 1'b1;
          instr       <= make_instr(kind);
          instr_test  <= 3'(kind);
        end else begin
          instr_valid <= 1'b0;  // gap or done
        end
      end
    end
  endtask

  task automatic run_test(input int kind);
    drive_test(kind, N_PER_TEST);
    step_clock();
    while (exp_q.size() != 0) step_clock();  // drain the slice
    $display("test %s done: %0d checks, %0d errors", names[kind], checks[kind], errors[kind]);
  endtask

  task automatic check_reset_state();
    @(posedge clk);
    checks[T_HS] += 2;
    if (dec_valid !== 1'b0) begin
      $display("dec_valid_o is not low after reset");
      errors[T_HS]++;
    end
    if (instr_ready !== 1'b1) begin
      $display("instr_ready_o is not high in the first cycle after reset");
      errors[T_HS]++;
    end
  endtask

  //////////////////////////////////////////////////
  // scoreboard
  //////////////////////////////////////////////////
  function automatic logic has_side_effect(input ctrl_dec_t c);
    return c.rf_we | c.data_req | c.data_we | c.mult_en | c.div_en | c.jump | c.branch |
           c.csr_access | c.icache_inval;
  endfunction

  always @(posedge clk) begin
    decoded_t exp;
    int       id;
    if (arst_n) begin
      if (stalled) begin  // record must hold under back-pressure
        checks[T_HS]++;
        if (dec_valid !== 1'b1) begin
          $display("dec_valid_o dropped while the output was stalled");
          errors[T_HS]++;
        end else if (dec !== held) begin
          $display("ERR %s: expected %h actual %h", names[T_HS], held, dec);
          errors[T_HS]++;
        end
      end
      if (accepted) begin  // one cycle from accept to valid
        checks[T_HS]++;
        if (dec_valid !== 1'b1) begin
          $display("dec_valid_o did not rise one cycle after an instruction was accepted");
          errors[T_HS]++;
        end
      end
      if (dec_valid && dec_ready) begin
        if (exp_q.size() == 0) begin
          checks[T_HS]++;
          $display("decoder produced an output with no instruction outstanding");
          errors[T_HS]++;
        end else begin
          exp = exp_q.pop_front();
          id  = id_q.pop_front();
          checks[id]++;
          if (dec !== exp) begin
            $display("ERR %s: expected %h actual %h", names[id], exp, dec);
            errors[id]++;
          end
          if (exp.ctrl.illegal) begin
            checks[id]++;
            if (!dec.ctrl.illegal || has_side_effect(dec.ctrl)) begin
              $display("%s: illegal instruction kept a side effect or lost its flag", names[id]);
              errors[id]++;
            end
          end
        end
      end
      if (instr_valid && instr_ready) begin
        exp_q.push_back(decode_word(instr));
        id_q.push_back(int'(instr_test));
      end
      stalled  = dec_valid && !dec_ready;
      accepted = instr_valid && instr_ready;
      held     = dec;
    end
  end

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////
  initial begin
    int k;
    int chk_total;
    int err_total;
    clk         = 1'b0;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    instr_test  = '0;
    dec_ready   = 1'b0;
    void'($urandom(41289));
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    check_reset_state();
    for (k = 0; k < N_KINDS; k++) run_test(k);
    $display("test %s done: %0d checks, %0d errors", names[T_HS], checks[T_HS], errors[T_HS]);
    chk_total = 0;
    err_total = 0;
    for (k = 0; k <= T_HS; k++) begin
      chk_total += checks[k];
      err_total += errors[k];
    end
    $display("total: %0d checks, %0d errors", chk_total, err_total);
    if (err_total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: not all instructions came out of the decoder in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== rv_decode.f ====
+incdir+testbench
src/rv_dec_pkg.sv
src/rv_ctrl_decoder.sv
src/rv_alu_decoder.sv
src/rv_dec_output_stage.sv
src/rv_decode_top.sv
testbench/tb_rv_decode.sv

// ==== Bender.yml ====
package:
  name: rv_decode

sources:
  - src/rv_dec_pkg.sv
  - src/rv_ctrl_decoder.sv
  - src/rv_alu_decoder.sv
  - src/rv_dec_output_stage.sv
  - src/rv_decode_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_rv_decode.sv
